// ==== files.f ====
led_matrix_pkg.sv
uart_rx.sv
cmd_decoder.sv
frame_buffer.sv
row_scanner.sv
led_matrix_ctrl.sv
led_matrix_properties.sv
tb_led_matrix_ctrl.sv

// ==== tb_led_matrix_ctrl.sv ====
module tb_led_matrix_ctrl
	import led_matrix_pkg::*;
();

	localparam int ticks_per_bit = 9;
	localparam int frame_cycles = 2048;
	// pixels in one matrix row
	localparam int row_pixels = 64;
	// channel chars, digits, three loads (one with a repeated L), two disables, unknowns
	localparam int total_bytes = 8 + 16 + 130 + 2 + 130 + 3 + 131;
	localparam int row_checks = 3;
	// each byte is 12 bit times; a row check waits up to a frame for pixel 0,0, then scans one
	localparam int timeout_cycles = total_bytes * 12 * ticks_per_bit
		+ row_checks * 2 * frame_cycles + 1000;

	logic clk_in;
	logic reset;
	logic uart_rx;
	logic rx_busy;
	rgb_t rgb_enable;
	bright_t brightness_enable;
	count_t lines_loaded;
	logic pixel_valid;
	row_t pixel_row;
	col_t pixel_col;
	pixel_t pixel_data;
	logic frame_start;

	// reference model state
	rgb_t m_rgb;
	bright_t m_bright;
	cmd_state_t m_state;
	row_t m_row;
	int m_pos;
	count_t m_lines;
	byte_t model_mem [4096];

	// frame scan handshake between the main process and the compare process
	logic scan_req = 1'b0;
	logic scan_active = 1'b0;
	logic scan_done = 1'b0;
	row_t scan_row;
	// position within the scanned frame, row-major
	int scan_pos;
	row_t exp_row;
	col_t exp_col;

	int seed;
	int cycle_count = 0;

	led_matrix_ctrl #(
		.ticks_per_bit(ticks_per_bit)
	) uut (
		.clk_in(clk_in),
		.reset(reset),
		.uart_rx(uart_rx),
		.rx_busy(rx_busy),
		.rgb_enable(rgb_enable),
		.brightness_enable(brightness_enable),
		.lines_loaded(lines_loaded),
		.pixel_valid(pixel_valid),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.pixel_data(pixel_data),
		.frame_start(frame_start)
	);

	initial begin
		clk_in = 1'b0;
		forever #4 clk_in = ~clk_in;
	end

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("Mismatch on %s: got 0x%0h, expected 0x%0h", name, actual, expected);
			$display("TEST FAILED");
			$fatal(1, "stopped at first error");
		end
	endtask

	// model of one received byte against the command rules
	function automatic void apply_byte(input byte_t b);
		int plane;
		case (m_state)
			cmd_idle: begin
				case (b)
					"R": m_rgb[0] = 1'b1;
					"r": m_rgb[0] = 1'b0;
					"G": m_rgb[1] = 1'b1;
					"g": m_rgb[1] = 1'b0;
					"B": m_rgb[2] = 1'b1;
					"b": m_rgb[2] = 1'b0;
					// digit 1 is plane 5, digit 6 is plane 0
					"1", "2", "3", "4", "5", "6": begin
						plane = 6 - (b - "0");
						m_bright[plane] = ~m_bright[plane];
					end
					"0": m_bright = '0;
					"9": m_bright = '1;
					"L": m_state = cmd_row;
					default: m_state = cmd_idle;
				endcase
			end
			cmd_row: begin
				if (b != "L") begin
					m_row = b[4:0];
					m_pos = 0;
					m_state = cmd_data;
				end
			end
			default: begin
				// bytes come in pairs per pixel from column 0, high byte first
				model_mem[{m_row, col_t'(m_pos / 2), (m_pos % 2 == 0)}] = b;
				m_pos++;
				if (m_pos == line_bytes) begin
					m_lines++;
					m_state = cmd_idle;
				end
			end
		endcase
	endfunction

	// stored 5-6-5 pixel with disabled fields cleared
	function automatic pixel_t expected_pixel(input row_t row, input col_t col);
		pixel_t p;
		p = {model_mem[{row, col, 1'b1}], model_mem[{row, col, 1'b0}]};
		if (!m_rgb[0]) p[15:11] = '0;
		if (!m_rgb[1]) p[10:5] = '0;
		if (!m_rgb[2]) p[4:0] = '0;
		return p;
	endfunction

	// random row byte that is never an L
	function automatic byte_t random_row_byte();
		int rnd;
		rnd = $random(seed);
		if (rnd[7:0] == "L") return rnd[7:0] ^ 8'h80;
		return rnd[7:0];
	endfunction

	task automatic drive_bit(input logic value);
		@(posedge clk_in);
		uart_rx <= value;
		repeat (ticks_per_bit - 1) @(posedge clk_in);
	endtask

	// start bit, data lsb first, stop bit, two idle bits
	task automatic send_byte(input byte_t b);
		drive_bit(1'b0);
		for (int k = 0; k < 8; k++) drive_bit(b[k]);
		// receiver still inside the frame after the last data bit
		@(negedge clk_in);
		check_value("rx_busy", rx_busy, 1'b1);
		repeat (3) drive_bit(1'b1);
		apply_byte(b);
		@(negedge clk_in);
		while (rx_busy) @(negedge clk_in);
	endtask

	// hand one frame scan of a row to the compare process
	task automatic verify_row(input row_t row);
		@(posedge clk_in);
		scan_row = row;
		scan_done = 1'b0;
		scan_req = 1'b1;
		wait (scan_done);
	endtask

	task automatic load_line(input byte_t row_byte, input bit repeat_l);
		count_t lines_before;
		int rnd;
		lines_before = m_lines;
		send_byte("L");
		if (repeat_l) begin
			send_byte("L");
			check_value("lines_loaded", lines_loaded, lines_before);
		end
		send_byte(row_byte);
		for (int k = 0; k < line_bytes; k++) begin
			rnd = $random(seed);
			send_byte(rnd[7:0]);
		end
		check_value("lines_loaded", lines_loaded, count_t'(lines_before + 1'b1));
		verify_row(row_byte[4:0]);
	endtask

	// compare process, one frame from pixel 0,0 once a scan is requested
	always @(negedge clk_in) begin
		if (scan_req && frame_start) begin
			scan_req = 1'b0;
			scan_active = 1'b1;
			scan_pos = 0;
		end
		if (scan_active) begin
			// expected coordinates walk the frame one pixel per clock
			exp_row = row_t'(scan_pos / row_pixels);
			exp_col = col_t'(scan_pos % row_pixels);
			check_value("pixel_valid", pixel_valid, 1'b1);
			check_value("frame_start", frame_start, scan_pos == 0);
			check_value("pixel_row", pixel_row, exp_row);
			check_value("pixel_col", pixel_col, exp_col);
			if (exp_row == scan_row) begin
				check_value("pixel_data", pixel_data, expected_pixel(exp_row, exp_col));
			end
			scan_pos++;
			if (scan_pos == frame_cycles) begin
				scan_active = 1'b0;
				scan_done = 1'b1;
			end
		end
	end

	always @(posedge clk_in) begin
		cycle_count++;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: run did not finish within %0d cycles", timeout_cycles);
			$display("TEST FAILED");
			$fatal(1, "timeout");
		end
	end

	initial begin
		string ch_seq;
		string unknown_seq;
		byte_t digits [8];
		byte_t tmp;
		int j;
		seed = 32'hd45a;
		reset = 1'b1;
		uart_rx = 1'b1;
		m_rgb = '1;
		m_bright = '1;
		m_state = cmd_idle;
		m_row = '0;
		m_pos = 0;
		m_lines = '0;
		ch_seq = "rgbRGBgG";
		unknown_seq = "x?Q";
		digits = '{"0", "1", "2", "3", "4", "5", "6", "9"};
		repeat (5) @(posedge clk_in);
		reset <= 1'b0;

		// reset values, pixel_valid up by the third cycle
		repeat (3) @(posedge clk_in);
		@(negedge clk_in);
		check_value("rgb_enable", rgb_enable, 3'b111);
		check_value("brightness_enable", brightness_enable, 6'h3f);
		check_value("lines_loaded", lines_loaded, 8'h00);
		check_value("pixel_valid", pixel_valid, 1'b1);

		// channel commands
		for (int i = 0; i < ch_seq.len(); i++) begin
			send_byte(ch_seq[i]);
			check_value("rgb_enable", rgb_enable, m_rgb);
		end

		// two shuffled rounds of the brightness digits
		repeat (2) begin
			for (int i = 7; i > 0; i--) begin
				j = $unsigned($random(seed)) % (i + 1);
				tmp = digits[i];
				digits[i] = digits[j];
				digits[j] = tmp;
			end
			for (int i = 0; i < 8; i++) begin
				send_byte(digits[i]);
				check_value("brightness_enable", brightness_enable, m_bright);
			end
		end

		// plain line load, all channels on
		load_line(random_row_byte(), 1'b0);

		// red and blue off
		send_byte("r");
		check_value("rgb_enable", rgb_enable, m_rgb);
		send_byte("b");
		check_value("rgb_enable", rgb_enable, m_rgb);
		load_line(random_row_byte(), 1'b0);

		// unknown characters leave every output alone
		for (int i = 0; i < unknown_seq.len(); i++) begin
			send_byte(unknown_seq[i]);
			check_value("rgb_enable", rgb_enable, m_rgb);
			check_value("brightness_enable", brightness_enable, m_bright);
			check_value("lines_loaded", lines_loaded, m_lines);
		end
		load_line(random_row_byte(), 1'b1);

		if (uut.u_cmd_decoder.u_props.failures != 0) begin
			$display("Assertions in the command decoder failed %0d times",
				uut.u_cmd_decoder.u_props.failures);
			$display("TEST FAILED");
			$fatal(1, "assertion failures");
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

endmodule

// ==== led_matrix_properties.sv ====
module led_matrix_properties
	import led_matrix_pkg::*;
(
	input logic clk_in,
	input logic reset,
	input cmd_state_t state,
	input logic [6:0] byte_idx,
	input logic rx_valid,
	input logic wr_en,
	input count_t lines_loaded
);

	// failed assertions, read by the testbench at the end of the run
	int failures = 0;

	// a write only follows a data byte taken in cmd_data
	write_from_data: assert property (@(posedge clk_in) disable iff (reset)
		wr_en |-> $past(rx_valid && (state == cmd_data)))
	else begin
		$error("wr_en without a data byte received in cmd_data");
		failures++;
	end

	// write pulse is one cycle wide
	write_single: assert property (@(posedge clk_in) disable iff (reset)
		wr_en |=> !wr_en)
	else begin
		$error("wr_en high for two cycles in a row");
		failures++;
	end

	// line count steps by one, and only after the index 0 data byte
	count_step: assert property (@(posedge clk_in) disable iff (reset)
		(lines_loaded != $past(lines_loaded)) |->
			(lines_loaded == count_t'($past(lines_loaded) + 1'b1)) &&
			$past(rx_valid && (state == cmd_data) && (byte_idx == '0)))
	else begin
		$error("lines_loaded changed outside the last data byte");
		failures++;
	end

	// byte strobe from the receiver lasts a single cycle
	strobe_single: assert property (@(posedge clk_in) disable iff (reset)
		rx_valid |=> !rx_valid)
	else begin
		$error("rx_valid high for two cycles in a row");
		failures++;
	end

endmodule

bind cmd_decoder led_matrix_properties u_props (
	.clk_in(clk_in),
	.reset(reset),
	.state(state),
	.byte_idx(byte_idx),
	.rx_valid(rx_valid),
	.wr_en(wr_en),
	.lines_loaded(lines_loaded)
);

// ==== led_matrix_ctrl.sv ====
module led_matrix_ctrl
	import led_matrix_pkg::*;
#(
	parameter int ticks_per_bit = 9
) (
	input logic clk_in,
	input logic reset,
	input logic uart_rx,
	output logic rx_busy,
	output rgb_t rgb_enable,
	output bright_t brightness_enable,
	output count_t lines_loaded,
	output logic pixel_valid,
	output row_t pixel_row,
	output col_t pixel_col,
	output pixel_t pixel_data,
	output logic frame_start
);

	// received byte and its strobe
	byte_t rx_byte;
	logic rx_valid;
	// frame buffer write port
	logic wr_en;
	fb_addr_t wr_addr;
	byte_t wr_data;
	// frame buffer read port
	row_t rd_row;
	col_t rd_col;
	pixel_t rd_data;

	// serial line to bytes
	uart_rx #(
		.ticks_per_bit(ticks_per_bit)
	) u_uart_rx (
		.clk_in(clk_in),
		.reset(reset),
		.rx_line(uart_rx),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rx_busy(rx_busy)
	);

	// bytes to enables and frame buffer writes
	cmd_decoder u_cmd_decoder (
		.clk_in(clk_in),
		.reset(reset),
		.rx_byte(rx_byte),
		.rx_valid(rx_valid),
		.rgb_enable(rgb_enable),
		.brightness_enable(brightness_enable),
		.lines_loaded(lines_loaded),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

	// 32 x 64 pixel store
	frame_buffer u_frame_buffer (
		.clk_in(clk_in),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.rd_data(rd_data)
	);

	// continuous frame readout
	row_scanner u_row_scanner (
		.clk_in(clk_in),
		.reset(reset),
		.rgb_enable(rgb_enable),
		.rd_data(rd_data),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.pixel_valid(pixel_valid),
		.pixel_row(pixel_row),
		.pixel_col(pixel_col),
		.pixel_data(pixel_data),
		.frame_start(frame_start)
	);

endmodule

// ==== row_scanner.sv ====
module row_scanner
	import led_matrix_pkg::*;
(
	input logic clk_in,
	input logic reset,
	input rgb_t rgb_enable,
	input pixel_t rd_data,
	output row_t rd_row,
	output col_t rd_col,
	output logic pixel_valid,
	output row_t pixel_row,
	output col_t pixel_col,
	output pixel_t pixel_data,
	output logic frame_start
);

	// coordinates of the read in flight, aligned with rd_data
	row_t d_row;
	col_t d_col;
	// rd_data holds a real pixel from here on
	logic d_valid;
	// field mask built from the channel enables
	pixel_t rgb_mask;

	// red field from bit 0, green from bit 1, blue from bit 2
	assign rgb_mask = {{5{rgb_enable[0]}}, {6{rgb_enable[1]}}, {5{rgb_enable[2]}}};

	// frame address counter, row-major order
	// one pixel per clock, 2048 clocks per frame
	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			rd_row <= '0;
			rd_col <= '0;
		end else begin
			rd_col <= rd_col + 1'b1;
			// last column of a row, move on to the next row
			// row wraps by itself after row 31
			if (rd_col == '1) begin
				rd_row <= rd_row + 1'b1;
			end
		end
	end

	// first read returns after one cycle
	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			d_valid <= 1'b0;
		end else begin
			d_valid <= 1'b1;
		end
	end

	// keep the coordinates in step with the read latency
	always_ff @(posedge clk_in) begin
		d_row <= rd_row;
		d_col <= rd_col;
	end

	// output strobes
	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			pixel_valid <= 1'b0;
			frame_start <= 1'b0;
		end else begin
			pixel_valid <= d_valid;
			// pulse with pixel 0,0 of every frame
			frame_start <= d_valid && (d_row == '0) && (d_col == '0);
		end
	end

	// output pixel, disabled channels zeroed here
	// so a mask change takes effect on the next pixel
	always_ff @(posedge clk_in) begin
		pixel_row <= d_row;
		pixel_col <= d_col;
		pixel_data <= rd_data & rgb_mask;
	end

endmodule

// ==== frame_buffer.sv ====
module frame_buffer
	import led_matrix_pkg::*;
(
	input logic clk_in,
	input logic wr_en,
	input fb_addr_t wr_addr,
	input byte_t wr_data,
	input row_t rd_row,
	input col_t rd_col,
	output pixel_t rd_data
);

	// pixel index {row, column}, one entry per pixel in each bank
	localparam int pixel_count = 1 << ($bits(row_t) + $bits(col_t));

	// high and low byte banks, together 4096 bytes
	byte_t bank_hi [pixel_count];
	byte_t bank_lo [pixel_count];

	logic [$bits(row_t)+$bits(col_t)-1:0] wr_idx;
	logic [$bits(row_t)+$bits(col_t)-1:0] rd_idx;

	// drop the byte select to get the pixel index
	assign wr_idx = wr_addr[11:1];
	assign rd_idx = {rd_row, rd_col};

	// byte select 1 goes to the high bank
	always_ff @(posedge clk_in) begin
		if (wr_en && wr_addr[0]) begin
			bank_hi[wr_idx] <= wr_data;
		end
		if (wr_en && !wr_addr[0]) begin
			bank_lo[wr_idx] <= wr_data;
		end
		// registered read, a same-cycle write shows up next time round
		rd_data <= {bank_hi[rd_idx], bank_lo[rd_idx]};
	end

endmodule

// ==== cmd_decoder.sv ====
module cmd_decoder
	import led_matrix_pkg::*;
(
	input logic clk_in,
	input logic reset,
	input byte_t rx_byte,
	input logic rx_valid,
	output rgb_t rgb_enable,
	output bright_t brightness_enable,
	output count_t lines_loaded,
	output logic wr_en,
	output fb_addr_t wr_addr,
	output byte_t wr_data
);

	// index of the first byte of a line, counts down to zero
	localparam logic [6:0] idx_first = 7'(line_bytes - 1);

	cmd_state_t state;
	row_t row;
	// byte index within the line load
	logic [6:0] byte_idx;
	logic data_byte;

	// a byte that belongs to a line load
	assign data_byte = rx_valid && (state == cmd_data);

	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			state <= cmd_idle;
			rgb_enable <= '1;
			brightness_enable <= '1;
			lines_loaded <= '0;
			row <= '0;
			byte_idx <= '0;
			wr_en <= 1'b0;
		end else begin
			// write pulse is one cycle wide
			wr_en <= 1'b0;
			if (rx_valid) begin
				case (state)
					cmd_idle: begin
						case (rx_byte)
							// channel enables
							ch_red_on: rgb_enable[0] <= 1'b1;
							ch_red_off: rgb_enable[0] <= 1'b0;
							ch_green_on: rgb_enable[1] <= 1'b1;
							ch_green_off: rgb_enable[1] <= 1'b0;
							ch_blue_on: rgb_enable[2] <= 1'b1;
							ch_blue_off: rgb_enable[2] <= 1'b0;
							// digit n toggles plane 6 - n
							ch_plane_1: begin
								brightness_enable[5] <= ~brightness_enable[5];
							end
							ch_plane_2: begin
								brightness_enable[4] <= ~brightness_enable[4];
							end
							ch_plane_3: begin
								brightness_enable[3] <= ~brightness_enable[3];
							end
							ch_plane_4: begin
								brightness_enable[2] <= ~brightness_enable[2];
							end
							ch_plane_5: begin
								brightness_enable[1] <= ~brightness_enable[1];
							end
							ch_plane_6: begin
								brightness_enable[0] <= ~brightness_enable[0];
							end
							// all planes off or all on
							ch_planes_off: brightness_enable <= '0;
							ch_planes_on: brightness_enable <= '1;
							// start of a line load, row byte comes next
							ch_line: state <= cmd_row;
							// unknown characters are dropped
							default: state <= cmd_idle;
						endcase
					end
					cmd_row: begin
						// a repeated L keeps waiting for the row
						if (rx_byte != ch_line) begin
							row <= rx_byte[4:0];
							byte_idx <= idx_first;
							state <= cmd_data;
						end
					end
					cmd_data: begin
						wr_en <= 1'b1;
						// index 0 is the low byte of the last pixel
						if (byte_idx == '0) begin
							lines_loaded <= lines_loaded + 1'b1;
							state <= cmd_idle;
						end else begin
							byte_idx <= byte_idx - 1'b1;
						end
					end
					default: begin
						state <= cmd_idle;
					end
				endcase
			end
		end
	end

	// column is the inverted upper index bits, so the first pair lands at pixel 0
	// index bit 0 picks the byte: odd index is the high byte, sent first
	always_ff @(posedge clk_in) begin
		if (data_byte) begin
			wr_addr <= {row, ~byte_idx[6:1], byte_idx[0]};
			wr_data <= rx_byte;
		end
	end

endmodule

// ==== uart_rx.sv ====
module uart_rx
	import led_matrix_pkg::*;
#(
	parameter int ticks_per_bit = 9
) (
	input logic clk_in,
	input logic reset,
	input logic rx_line,
	output byte_t rx_byte,
	output logic rx_valid,
	output logic rx_busy
);

	// tick counter wide enough for one full bit time
	localparam int tick_w = $clog2(ticks_per_bit + 1);
	typedef logic [tick_w-1:0] tick_t;
	// last tick of a bit, and the tick that lands mid-bit from an edge
	localparam tick_t tick_last = tick_t'(ticks_per_bit - 1);
	localparam tick_t tick_half = tick_t'((ticks_per_bit - 1) / 2);

	// receiver states
	typedef enum logic [2:0] {
		rx_idle,
		rx_start,
		rx_data,
		rx_stop,
		rx_finish
	} rx_state_t;

	rx_state_t state;
	tick_t tick_cnt;
	logic [2:0] bit_idx;
	// two-flop synchroniser plus one flop for edge detect
	logic rx_meta;
	logic rx_sync;
	logic rx_prev;
	logic start_edge;
	logic sample_data;

	// line idles high, so the flops reset high
	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= rx_line;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	// high to low on the synchronised line
	assign start_edge = rx_prev & ~rx_sync;
	// centre of a data bit
	assign sample_data = (state == rx_data) && (tick_cnt == tick_last);

	always_ff @(posedge clk_in or posedge reset) begin
		if (reset) begin
			state <= rx_idle;
			tick_cnt <= '0;
			bit_idx <= '0;
			rx_valid <= 1'b0;
		end else begin
			// strobe lasts a single cycle
			rx_valid <= 1'b0;
			case (state)
				rx_idle: begin
					tick_cnt <= '0;
					if (start_edge) begin
						state <= rx_start;
					end
				end
				rx_start: begin
					// half a bit in, the line must still be low
					if (tick_cnt == tick_half) begin
						tick_cnt <= '0;
						bit_idx <= '0;
						state <= rx_sync ? rx_idle : rx_data;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				rx_data: begin
					if (tick_cnt == tick_last) begin
						tick_cnt <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= rx_stop;
						end
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				rx_stop: begin
					// a low stop bit is a framing error, no strobe
					if (tick_cnt == tick_last) begin
						tick_cnt <= '0;
						rx_valid <= rx_sync;
						state <= rx_finish;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				rx_finish: begin
					// wait out the back half of the stop bit
					if (tick_cnt == tick_half) begin
						tick_cnt <= '0;
						state <= rx_idle;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end
				default: begin
					state <= rx_idle;
				end
			endcase
		end
	end

	// lsb first, so shift in from the top
	always_ff @(posedge clk_in) begin
		if (sample_data) begin
			rx_byte <= {rx_sync, rx_byte[7:1]};
		end
	end

	// busy from start edge through the end of the stop bit
	assign rx_busy = (state != rx_idle);

endmodule

// ==== led_matrix_pkg.sv ====
package led_matrix_pkg;

	// one serial byte, also one frame buffer byte
	typedef logic [7:0] byte_t;
	// 5-6-5 pixel: red [15:11], green [10:5], blue [4:0]
	typedef logic [15:0] pixel_t;
	// matrix row 0..31 and pixel column 0..63
	typedef logic [4:0] row_t;
	typedef logic [5:0] col_t;
	// byte address {row, column, byte select}, select 1 is the high byte
	typedef logic [11:0] fb_addr_t;
	// channel enables: bit 0 red, bit 1 green, bit 2 blue
	typedef logic [2:0] rgb_t;
	// brightness plane enables
	typedef logic [5:0] bright_t;
	// completed line loads
	typedef logic [7:0] count_t;

	// command interpreter states
	typedef enum logic [1:0] {
		cmd_idle,
		cmd_row,
		cmd_data
	} cmd_state_t;

	// data bytes in one line load, 64 pixels of two bytes
	localparam int line_bytes = 128;

	// channel commands, upper case sets and lower case clears
	localparam byte_t ch_red_on = "R";
	localparam byte_t ch_red_off = "r";
	localparam byte_t ch_green_on = "G";
	localparam byte_t ch_green_off = "g";
	localparam byte_t ch_blue_on = "B";
	localparam byte_t ch_blue_off = "b";
	// brightness commands
	localparam byte_t ch_planes_off = "0";
	localparam byte_t ch_plane_1 = "1";
	localparam byte_t ch_plane_2 = "2";
	localparam byte_t ch_plane_3 = "3";
	localparam byte_t ch_plane_4 = "4";
	localparam byte_t ch_plane_5 = "5";
	localparam byte_t ch_plane_6 = "6";
	localparam byte_t ch_planes_on = "9";
	// line load command
	localparam byte_t ch_line = "L";

endpackage
